//--- wiscPkg.sv
// WISC core shared types
package wiscPkg;

    // Instructions, data and addresses are all one word wide
    typedef logic [15:0] wordT;

    // Index into the eight-entry register file
    typedef logic [2:0] regIdxT;

    // Opcode field, bits 15:11 of every instruction
    typedef enum logic [4:0] {
        opHalt = 5'b00000,
        opNop  = 5'b00001,
        opJ    = 5'b00100,
        opAddi = 5'b01000,
        opBeqz = 5'b01100,
        opSt   = 5'b10000,
        opLd   = 5'b10001,
        opAlu  = 5'b11011
    } opcodeT;

    // ALU functions; SUB computes Rt - Rs and ANDN computes Rs & ~Rt
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluAndn,
        aluPass
    } aluOpT;

    // Bubble inserted by the hazard unit
    localparam wordT nopInst = {5'b00001, 11'b0};

endpackage

//--- unifiedMem.sv
// Unified instruction and data memory
`timescale 1ns/1ps
module unifiedMem #(
    parameter int memWords = 256
) (
    input  logic          clk,
    input  logic          en,
    input  logic          we,
    input  wiscPkg::wordT addr,
    input  wiscPkg::wordT wdata,
    output wiscPkg::wordT rdata
);
    localparam int addrBits = $clog2(memWords);

    wiscPkg::wordT mem [memWords];

    // Word addressed, upper address bits ignored
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr[addrBits-1:0]] <= wdata;
            end else begin
                rdata <= mem[addr[addrBits-1:0]];
            end
        end
    end

endmodule

//--- memArbiter.sv
// Fixed-priority memory arbiter
`timescale 1ns/1ps
module memArbiter (
    input  logic          clk,
    input  logic          rst,
    input  logic          ldWe,
    input  wiscPkg::wordT ldAddr,
    input  wiscPkg::wordT ldData,
    input  logic          dReq,
    input  logic          dWe,
    input  wiscPkg::wordT dAddr,
    input  wiscPkg::wordT dWdata,
    input  logic          iReq,
    input  wiscPkg::wordT iAddr,
    output logic          gntD,
    output logic          gntI,
    output logic          memEn,
    output logic          memWe,
    output wiscPkg::wordT memAddr,
    output wiscPkg::wordT memWdata
);
    // Loader first, then the data port, fetch takes what is left
    assign gntD  = dReq && !ldWe;
    assign gntI  = iReq && !ldWe && !dReq;
    assign memEn = ldWe || dReq || iReq;
    assign memWe = ldWe || (gntD && dWe);

    always_comb begin
        if (ldWe) begin
            memAddr  = ldAddr;
            memWdata = ldData;
        end else if (dReq) begin
            memAddr  = dAddr;
            memWdata = dWdata;
        end else begin
            memAddr  = iAddr;
            memWdata = dWdata;
        end
    end

    // The data port never waits for the memory
    assert property (@(posedge clk) disable iff (rst) dReq |-> gntD)
        else $error("memArbiter: data port request not granted");

endmodule

//--- fetchUnit.sv
// Instruction fetch
`timescale 1ns/1ps
module fetchUnit (
    input  logic          clk,
    input  logic          rst,
    input  logic          run,
    input  logic          gntI,
    input  wiscPkg::wordT memRdata,
    output logic          iReq,
    output wiscPkg::wordT iAddr,
    input  logic          pcNop,
    input  logic          redirect,
    input  wiscPkg::wordT redirectPc,
    output wiscPkg::wordT fetchInst,
    output logic          fetchValid,
    output wiscPkg::wordT fetchPc
);
    wiscPkg::wordT pc;
    wiscPkg::wordT instReg;
    logic          valid;
    logic          pending;

    // Hold off a new read in the cycle the PC is being redirected
    assign iReq       = run && !valid && !pending && !redirect;
    assign iAddr      = pc;
    assign fetchInst  = valid ? instReg : wiscPkg::nopInst;
    assign fetchValid = valid;
    assign fetchPc    = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            valid   <= 1'b0;
            pending <= 1'b0;
        end else if (redirect) begin
            // Drops any fall-through instruction held or in flight
            pc      <= redirectPc;
            valid   <= 1'b0;
            pending <= 1'b0;
        end else begin
            pending <= gntI;
            if (pending) begin
                valid <= 1'b1;
            end else if (valid && !pcNop) begin
                valid <= 1'b0;
                pc    <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending) begin
            instReg <= memRdata;
        end
    end

endmodule

//--- hazardDetect.sv
// RAW and control hazard detection
`timescale 1ns/1ps
module hazardDetect (
    input  wiscPkg::wordT   fetchInst,
    input  logic            fetchValid,
    input  logic            regWrtD,
    input  logic            regWrtX,
    input  logic            regWrtM,
    input  logic            regWrtW,
    input  wiscPkg::regIdxT wrtRegD,
    input  wiscPkg::regIdxT wrtRegX,
    input  wiscPkg::regIdxT wrtRegM,
    input  wiscPkg::regIdxT wrtRegW,
    input  logic            branchInstD,
    input  logic            branchInstX,
    output wiscPkg::wordT   nextInst,
    output logic            pcNop,
    output logic            branchInstF
);
    wiscPkg::opcodeT op;
    logic            readRs;
    logic            readRt;
    logic            isCtrl;
    logic            rsHazard;
    logic            rtHazard;

    // True when any later stage is about to write register r
    function automatic logic pendingWrite(input wiscPkg::regIdxT r);
        pendingWrite = (regWrtD && r == wrtRegD) || (regWrtX && r == wrtRegX) ||
                       (regWrtM && r == wrtRegM) || (regWrtW && r == wrtRegW);
    endfunction

    assign op = wiscPkg::opcodeT'(fetchInst[15:11]);

    // Which source fields each opcode reads
    always_comb begin
        readRs = 1'b0;
        readRt = 1'b0;
        isCtrl = 1'b0;
        case (op)
            // Rs and Rt, ST reads its data register from bits 7:5
            wiscPkg::opAlu,
            wiscPkg::opSt: begin
                readRs = 1'b1;
                readRt = 1'b1;
            end
            wiscPkg::opAddi,
            wiscPkg::opLd: begin
                readRs = 1'b1;
            end
            wiscPkg::opBeqz: begin
                readRs = 1'b1;
                isCtrl = 1'b1;
            end
            wiscPkg::opJ: begin
                isCtrl = 1'b1;
            end
            // NOP and HALT read nothing
            default: begin
            end
        endcase
    end

    assign rsHazard = readRs && pendingWrite(fetchInst[10:8]);
    assign rtHazard = readRt && pendingWrite(fetchInst[7:5]);

    // Any conflict, or a branch still unresolved, holds fetch and sends a bubble
    assign pcNop       = fetchValid && (rsHazard || rtHazard || branchInstD || branchInstX);
    assign nextInst    = (fetchValid && !pcNop) ? fetchInst : wiscPkg::nopInst;
    assign branchInstF = fetchValid && !pcNop && isCtrl;

endmodule

//--- decodeStage.sv
// Decode stage and register file
`timescale 1ns/1ps
module decodeStage (
    input  logic            clk,
    input  logic            rst,
    input  wiscPkg::wordT   nextInst,
    input  wiscPkg::wordT   fetchPc,
    input  logic            branchInstF,
    input  logic            wbEn,
    input  wiscPkg::regIdxT wbReg,
    input  wiscPkg::wordT   wbData,
    output logic            regWrtD,
    output wiscPkg::regIdxT wrtRegD,
    output logic            branchInstD,
    output wiscPkg::wordT   opA,
    output wiscPkg::wordT   opB,
    output wiscPkg::wordT   imm,
    output wiscPkg::aluOpT  aluOp,
    output wiscPkg::regIdxT destReg,
    output logic            regWrt,
    output logic            isLoad,
    output logic            isStore,
    output logic            isBeqz,
    output logic            isJump,
    output logic            isHalt,
    output wiscPkg::wordT   pcOut
);
    wiscPkg::wordT   regs [8];
    wiscPkg::wordT   dInst;
    wiscPkg::wordT   dPc;
    wiscPkg::wordT   dImm;
    wiscPkg::opcodeT dOp;
    wiscPkg::aluOpT  dAluOp;
    logic            immOperand;
    logic            dLoad;
    logic            dStore;
    logic            dBeqz;
    logic            dJump;
    logic            dHalt;

    assign dOp = wiscPkg::opcodeT'(dInst[15:11]);

    // Instruction register at the head of D
    always_ff @(posedge clk) begin
        if (rst) begin
            dInst       <= wiscPkg::nopInst;
            branchInstD <= 1'b0;
        end else begin
            dInst       <= nextInst;
            branchInstD <= branchInstF;
        end
    end

    always_ff @(posedge clk) begin
        dPc <= fetchPc;
    end

    // Written at the edge that ends W
    always_ff @(posedge clk) begin
        if (wbEn) begin
            regs[wbReg] <= wbData;
        end
    end

    always_comb begin
        regWrtD    = 1'b0;
        wrtRegD    = dInst[7:5];
        dAluOp     = wiscPkg::aluPass;
        immOperand = 1'b0;
        dLoad      = 1'b0;
        dStore     = 1'b0;
        dBeqz      = 1'b0;
        dJump      = 1'b0;
        dHalt      = 1'b0;
        dImm       = {{11{dInst[4]}}, dInst[4:0]};
        case (dOp)
            wiscPkg::opAlu: begin
                regWrtD = 1'b1;
                wrtRegD = dInst[4:2];
                case (dInst[1:0])
                    2'b00: dAluOp = wiscPkg::aluAdd;
                    2'b01: dAluOp = wiscPkg::aluSub;
                    2'b10: dAluOp = wiscPkg::aluXor;
                    default: dAluOp = wiscPkg::aluAndn;
                endcase
            end
            wiscPkg::opAddi: begin
                regWrtD    = 1'b1;
                dAluOp     = wiscPkg::aluAdd;
                immOperand = 1'b1;
            end
            wiscPkg::opLd: begin
                regWrtD    = 1'b1;
                dAluOp     = wiscPkg::aluAdd;
                immOperand = 1'b1;
                dLoad      = 1'b1;
            end
            // Store keeps Rt in opB as its data, X adds imm for the address
            wiscPkg::opSt: begin
                dAluOp = wiscPkg::aluAdd;
                dStore = 1'b1;
            end
            wiscPkg::opBeqz: begin
                dBeqz = 1'b1;
                dImm  = {{8{dInst[7]}}, dInst[7:0]};
            end
            wiscPkg::opJ: begin
                dJump = 1'b1;
                dImm  = {{5{dInst[10]}}, dInst[10:0]};
            end
            wiscPkg::opHalt: begin
                dHalt = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // D/X register
    always_ff @(posedge clk) begin
        if (rst) begin
            regWrt  <= 1'b0;
            isLoad  <= 1'b0;
            isStore <= 1'b0;
            isBeqz  <= 1'b0;
            isJump  <= 1'b0;
            isHalt  <= 1'b0;
        end else begin
            regWrt  <= regWrtD;
            isLoad  <= dLoad;
            isStore <= dStore;
            isBeqz  <= dBeqz;
            isJump  <= dJump;
            isHalt  <= dHalt;
        end
    end

    always_ff @(posedge clk) begin
        opA     <= regs[dInst[10:8]];
        opB     <= immOperand ? dImm : regs[dInst[7:5]];
        imm     <= dImm;
        aluOp   <= dAluOp;
        destReg <= wrtRegD;
        pcOut   <= dPc;
    end

endmodule

//--- executeStage.sv
// Execute stage with branch resolution
`timescale 1ns/1ps
module executeStage (
    input  logic            clk,
    input  logic            rst,
    input  wiscPkg::wordT   opA,
    input  wiscPkg::wordT   opB,
    input  wiscPkg::wordT   imm,
    input  wiscPkg::aluOpT  aluOp,
    input  wiscPkg::regIdxT destReg,
    input  logic            regWrt,
    input  logic            isLoad,
    input  logic            isStore,
    input  logic            isBeqz,
    input  logic            isJump,
    input  logic            isHalt,
    input  wiscPkg::wordT   pcOut,
    output logic            redirect,
    output wiscPkg::wordT   redirectPc,
    output logic            regWrtX,
    output wiscPkg::regIdxT wrtRegX,
    output logic            branchInstX,
    output wiscPkg::wordT   aluRes,
    output wiscPkg::wordT   storeData,
    output wiscPkg::regIdxT mDestReg,
    output logic            mRegWrt,
    output logic            mIsLoad,
    output logic            mIsStore,
    output logic            mIsHalt
);
    wiscPkg::wordT aluB;
    wiscPkg::wordT result;

    assign aluB = isStore ? imm : opB;

    always_comb begin
        case (aluOp)
            wiscPkg::aluAdd:  result = opA + aluB;
            wiscPkg::aluSub:  result = aluB - opA;
            wiscPkg::aluXor:  result = opA ^ aluB;
            wiscPkg::aluAndn: result = opA & ~aluB;
            default:          result = opA;
        endcase
    end

    // Targets are relative to the following instruction
    assign redirect   = isJump || (isBeqz && opA == 16'd0);
    assign redirectPc = pcOut + 16'd1 + imm;

    assign regWrtX     = regWrt;
    assign wrtRegX     = destReg;
    assign branchInstX = isBeqz || isJump;

    // X/M register
    always_ff @(posedge clk) begin
        if (rst) begin
            mRegWrt  <= 1'b0;
            mIsLoad  <= 1'b0;
            mIsStore <= 1'b0;
            mIsHalt  <= 1'b0;
        end else begin
            mRegWrt  <= regWrt;
            mIsLoad  <= isLoad;
            mIsStore <= isStore;
            mIsHalt  <= isHalt;
        end
    end

    always_ff @(posedge clk) begin
        aluRes    <= result;
        storeData <= opB;
        mDestReg  <= destReg;
    end

endmodule

//--- memStage.sv
// Memory access and writeback
`timescale 1ns/1ps
module memStage (
    input  logic            clk,
    input  logic            rst,
    input  wiscPkg::wordT   aluRes,
    input  wiscPkg::wordT   storeData,
    input  wiscPkg::regIdxT destReg,
    input  logic            regWrt,
    input  logic            isLoad,
    input  logic            isStore,
    input  logic            isHalt,
    output logic            dReq,
    output logic            dWe,
    output wiscPkg::wordT   dAddr,
    output wiscPkg::wordT   dWdata,
    input  logic            gntD,
    input  wiscPkg::wordT   memRdata,
    output logic            regWrtM,
    output wiscPkg::regIdxT wrtRegM,
    output logic            regWrtW,
    output wiscPkg::regIdxT wrtRegW,
    output logic            wbEn,
    output wiscPkg::regIdxT wbReg,
    output wiscPkg::wordT   wbData,
    output logic            halted
);
    wiscPkg::wordT wRes;
    logic          wLoad;

    // Nothing behind a HALT touches memory
    assign dReq   = (isLoad || isStore) && !halted;
    assign dWe    = isStore;
    assign dAddr  = aluRes;
    assign dWdata = storeData;

    assign regWrtM = regWrt;
    assign wrtRegM = destReg;
    assign regWrtW = wbEn;
    assign wrtRegW = wbReg;

    // Load data returns during W
    assign wbData = wLoad ? memRdata : wRes;

    // M/W register and halt latch
    always_ff @(posedge clk) begin
        if (rst) begin
            wbEn   <= 1'b0;
            wLoad  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wbEn  <= regWrt && !halted;
            wLoad <= gntD && !dWe;
            if (isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wRes  <= aluRes;
        wbReg <= destReg;
    end

endmodule

//--- wiscCore.sv
// WISC pipelined core
`timescale 1ns/1ps
module wiscCore #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            ldWe,
    input  wiscPkg::wordT   ldAddr,
    input  wiscPkg::wordT   ldData,
    output logic            halted,
    output logic            wbEn,
    output wiscPkg::regIdxT wbReg,
    output wiscPkg::wordT   wbData
);
    logic dReq, dWe, gntD, iReq, gntI, memEn, memWe;
    wiscPkg::wordT dAddr, dWdata, iAddr, memAddr, memWdata, memRdata;
    logic pcNop, redirect, fetchValid, branchInstF, branchInstD, branchInstX;
    wiscPkg::wordT redirectPc, fetchInst, fetchPc, nextInst;
    logic regWrtD, regWrtX, regWrtM, regWrtW;
    wiscPkg::regIdxT wrtRegD, wrtRegX, wrtRegM, wrtRegW;

    // D/X bundle
    wiscPkg::wordT opA, opB, imm, pcOut;
    wiscPkg::aluOpT aluOp;
    wiscPkg::regIdxT xDest;
    logic xWrt, xLoad, xStore, xBeqz, xJump, xHalt;

    // X/M bundle
    wiscPkg::wordT aluRes, storeData;
    wiscPkg::regIdxT mDest;
    logic mWrt, mLoad, mStore, mHalt;

    unifiedMem #(.memWords(memWords)) mem (
        .clk(clk), .en(memEn), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
    );

    memArbiter arb (
        .clk(clk), .rst(rst), .ldWe(ldWe), .ldAddr(ldAddr), .ldData(ldData),
        .dReq(dReq), .dWe(dWe), .dAddr(dAddr), .dWdata(dWdata), .iReq(iReq), .iAddr(iAddr),
        .gntD(gntD), .gntI(gntI), .memEn(memEn), .memWe(memWe), .memAddr(memAddr),
        .memWdata(memWdata)
    );

    fetchUnit fetch (
        .clk(clk), .rst(rst), .run(run), .gntI(gntI), .memRdata(memRdata), .iReq(iReq),
        .iAddr(iAddr), .pcNop(pcNop), .redirect(redirect), .redirectPc(redirectPc),
        .fetchInst(fetchInst), .fetchValid(fetchValid), .fetchPc(fetchPc)
    );

    hazardDetect hazard (
        .fetchInst(fetchInst), .fetchValid(fetchValid), .regWrtD(regWrtD), .regWrtX(regWrtX),
        .regWrtM(regWrtM), .regWrtW(regWrtW), .wrtRegD(wrtRegD), .wrtRegX(wrtRegX),
        .wrtRegM(wrtRegM), .wrtRegW(wrtRegW), .branchInstD(branchInstD),
        .branchInstX(branchInstX), .nextInst(nextInst), .pcNop(pcNop),
        .branchInstF(branchInstF)
    );

    decodeStage decode (
        .clk(clk), .rst(rst), .nextInst(nextInst), .fetchPc(fetchPc),
        .branchInstF(branchInstF), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .regWrtD(regWrtD), .wrtRegD(wrtRegD), .branchInstD(branchInstD), .opA(opA),
        .opB(opB), .imm(imm), .aluOp(aluOp), .destReg(xDest), .regWrt(xWrt), .isLoad(xLoad),
        .isStore(xStore), .isBeqz(xBeqz), .isJump(xJump), .isHalt(xHalt), .pcOut(pcOut)
    );

    executeStage execute (
        .clk(clk), .rst(rst), .opA(opA), .opB(opB), .imm(imm), .aluOp(aluOp),
        .destReg(xDest), .regWrt(xWrt), .isLoad(xLoad), .isStore(xStore), .isBeqz(xBeqz),
        .isJump(xJump), .isHalt(xHalt), .pcOut(pcOut), .redirect(redirect),
        .redirectPc(redirectPc), .regWrtX(regWrtX), .wrtRegX(wrtRegX),
        .branchInstX(branchInstX), .aluRes(aluRes), .storeData(storeData),
        .mDestReg(mDest), .mRegWrt(mWrt), .mIsLoad(mLoad), .mIsStore(mStore),
        .mIsHalt(mHalt)
    );

    memStage memory (
        .clk(clk), .rst(rst), .aluRes(aluRes), .storeData(storeData), .destReg(mDest),
        .regWrt(mWrt), .isLoad(mLoad), .isStore(mStore), .isHalt(mHalt), .dReq(dReq),
        .dWe(dWe), .dAddr(dAddr), .dWdata(dWdata), .gntD(gntD), .memRdata(memRdata),
        .regWrtM(regWrtM), .wrtRegM(wrtRegM), .regWrtW(regWrtW), .wrtRegW(wrtRegW),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted)
    );

    // The data port never waits only if the loader stays quiet while the core runs
    assert property (@(posedge clk) disable iff (rst) ldWe |-> !run)
        else $error("wiscCore: program loader active while the core is running");

endmodule

//--- tbClock.sv
// Testbench clock and reset
`timescale 1ns/1ps
module tbClock #(
    parameter int resetCycles = 4
) (
    input  logic restart,
    output logic clk,
    output logic rst
);
    int rstLeft = resetCycles;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign rst = (rstLeft != 0);

    // A restart pulse holds reset for another resetCycles edges
    always @(posedge clk) begin
        if (restart) begin
            rstLeft <= resetCycles;
        end else if (rstLeft != 0) begin
            rstLeft <= rstLeft - 1;
        end
    end

endmodule

//--- wiscCoreTb.sv
// WISC core testbench
`timescale 1ns/1ps
module wiscCoreTb;
    localparam int memWords = 256;
    localparam int fnAdd = 0;
    localparam int fnSub = 1;
    localparam int fnXor = 2;
    localparam int fnAndn = 3;
    localparam wiscPkg::wordT haltWord = {wiscPkg::opHalt, 11'b0};

    logic            clk;
    logic            rst;
    logic            restart;
    logic            run;
    logic            ldWe;
    wiscPkg::wordT   ldAddr;
    wiscPkg::wordT   ldData;
    logic            halted;
    logic            wbEn;
    wiscPkg::regIdxT wbReg;
    wiscPkg::wordT   wbData;

    // Program images stored back to back
    wiscPkg::wordT   image [512];
    int              startAt [5];
    int              lenOf [5];
    int              fill;

    // ISA view of memory next to the DUT memory
    wiscPkg::wordT   refMem [memWords];
    wiscPkg::regIdxT expReg [$];
    wiscPkg::wordT   expData [$];

    wiscPkg::regIdxT clearIdx;
    logic            checking;
    int              commits;
    int              errors;
    int              testsOk;
    int              testsBad;
    int              budget;
    int              seed;

    tbClock clkGen (
        .restart(restart), .clk(clk), .rst(rst)
    );

    wiscCore #(.memWords(memWords)) dut (
        .clk(clk), .rst(rst), .run(run), .ldWe(ldWe), .ldAddr(ldAddr), .ldData(ldData),
        .halted(halted), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
    );

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Instruction encoders
    function automatic wiscPkg::wordT aluInst(input int func, input int rd, input int rs,
                                              input int rt);
        aluInst = {wiscPkg::opAlu, rs[2:0], rt[2:0], rd[2:0], func[1:0]};
    endfunction

    function automatic wiscPkg::wordT addiInst(input int rd, input int rs, input int imm);
        addiInst = {wiscPkg::opAddi, rs[2:0], rd[2:0], imm[4:0]};
    endfunction

    function automatic wiscPkg::wordT ldInst(input int rd, input int rs, input int imm);
        ldInst = {wiscPkg::opLd, rs[2:0], rd[2:0], imm[4:0]};
    endfunction

    function automatic wiscPkg::wordT stInst(input int rt, input int rs, input int imm);
        stInst = {wiscPkg::opSt, rs[2:0], rt[2:0], imm[4:0]};
    endfunction

    function automatic wiscPkg::wordT beqzInst(input int rs, input int offset);
        beqzInst = {wiscPkg::opBeqz, rs[2:0], offset[7:0]};
    endfunction

    function automatic wiscPkg::wordT jumpInst(input int offset);
        jumpInst = {wiscPkg::opJ, offset[10:0]};
    endfunction

    task automatic emit(input wiscPkg::wordT w);
        image[fill] = w;
        fill++;
    endtask

    task automatic openProgram(input int t);
        startAt[t] = fill;
    endtask

    // Fetch runs on past HALT, so each image ends in spare HALT words
    task automatic closeProgram(input int t);
        int k;
        for (k = 0; k < 8; k++) begin
            emit(haltWord);
        end
        lenOf[t] = fill - startAt[t];
    endtask

    task automatic buildPrograms();
        int k;
        int r;
        fill = 0;
        // Each instruction reads the result of the one before it
        openProgram(0);
        emit(addiInst(1, 0, 7));
        emit(addiInst(2, 1, -3));
        emit(aluInst(fnAdd, 3, 2, 1));
        emit(aluInst(fnSub, 4, 3, 2));
        emit(aluInst(fnXor, 5, 4, 3));
        emit(aluInst(fnAndn, 6, 5, 4));
        emit(aluInst(fnAdd, 1, 6, 6));
        emit(haltWord);
        closeProgram(0);
        openProgram(1);
        for (k = 1; k < 8; k++) begin
            r = $random(seed);
            emit(addiInst(k, 0, r));
        end
        for (k = 0; k < 8; k++) begin
            r = $random(seed);
            emit(aluInst(r[1:0], r[4:2], r[7:5], r[10:8]));
        end
        emit(haltWord);
        closeProgram(1);
        // Base 240 keeps the data well away from the code
        openProgram(2);
        emit(addiInst(1, 0, 15));
        for (k = 0; k < 4; k++) begin
            emit(aluInst(fnAdd, 1, 1, 1));
        end
        r = $random(seed);
        emit(addiInst(2, 0, r));
        emit(aluInst(fnAdd, 3, 2, 1));
        emit(stInst(3, 1, 3));
        emit(ldInst(4, 1, 3));
        emit(stInst(2, 1, -2));
        emit(ldInst(5, 1, -2));
        emit(aluInst(fnXor, 6, 4, 5));
        emit(haltWord);
        closeProgram(2);
        openProgram(3);
        emit(addiInst(1, 0, 5));
        emit(beqzInst(1, 2));
        emit(addiInst(2, 0, 1));
        emit(beqzInst(0, 1));
        emit(addiInst(3, 0, 9));
        emit(jumpInst(1));
        emit(addiInst(4, 0, 3));
        emit(addiInst(5, 1, -1));
        emit(jumpInst(2));
        emit(addiInst(6, 0, 4));
        emit(jumpInst(2));
        emit(addiInst(7, 0, -6));
        emit(jumpInst(-4));
        emit(haltWord);
        closeProgram(3);
        // Writes placed after the HALT must never commit
        openProgram(4);
        emit(addiInst(1, 0, 3));
        emit(addiInst(2, 1, 4));
        emit(haltWord);
        emit(addiInst(3, 0, 1));
        emit(aluInst(fnAdd, 4, 1, 2));
        emit(addiInst(5, 0, 6));
        closeProgram(4);
    endtask

    // ISA interpreter over refMem starting at PC 0 with all registers zero
    function automatic int referenceRun();
        wiscPkg::wordT   regs [8];
        wiscPkg::wordT   inst;
        wiscPkg::wordT   pc;
        wiscPkg::wordT   rsVal;
        wiscPkg::wordT   rtVal;
        wiscPkg::wordT   addr;
        wiscPkg::wordT   res;
        wiscPkg::regIdxT rd;
        logic            writes;
        logic            done;
        int              steps;
        int              count;
        int              i;
        for (i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        expReg.delete();
        expData.delete();
        pc = '0;
        done = 1'b0;
        steps = 0;
        count = 0;
        while (!done && steps < 4096) begin
            inst = refMem[int'(pc) % memWords];
            rsVal = regs[inst[10:8]];
            rtVal = regs[inst[7:5]];
            addr = rsVal + {{11{inst[4]}}, inst[4:0]};
            pc = pc + 16'd1;
            steps++;
            writes = 1'b0;
            rd = inst[7:5];
            res = '0;
            case (inst[15:11])
                wiscPkg::opAlu: begin
                    writes = 1'b1;
                    rd = inst[4:2];
                    case (inst[1:0])
                        2'd0: res = rsVal + rtVal;
                        2'd1: res = rtVal - rsVal;
                        2'd2: res = rsVal ^ rtVal;
                        default: res = rsVal & ~rtVal;
                    endcase
                end
                wiscPkg::opAddi: begin
                    writes = 1'b1;
                    res = addr;
                end
                wiscPkg::opLd: begin
                    writes = 1'b1;
                    res = refMem[int'(addr) % memWords];
                end
                wiscPkg::opSt: begin
                    refMem[int'(addr) % memWords] = rtVal;
                end
                // Branch offsets count from the next instruction
                wiscPkg::opBeqz: begin
                    if (rsVal == 16'd0) begin
                        pc = pc + {{8{inst[7]}}, inst[7:0]};
                    end
                end
                wiscPkg::opJ: begin
                    pc = pc + {{5{inst[10]}}, inst[10:0]};
                end
                wiscPkg::opNop: begin
                end
                default: begin
                    done = 1'b1;
                end
            endcase
            if (writes) begin
                regs[rd] = res;
                expReg.push_back(rd);
                expData.push_back(res);
                count++;
            end
        end
        return count;
    endfunction

    // Register file powers up unknown
    // Zero it through the writeback port while the core is idle
    task automatic clearRegs();
        int i;
        clearIdx = '0;
        @(negedge clk);
        force dut.decode.wbEn = 1'b1;
        force dut.decode.wbData = 16'h0000;
        force dut.decode.wbReg = clearIdx;
        for (i = 0; i < 8; i++) begin
            clearIdx = wiscPkg::regIdxT'(i);
            @(negedge clk);
        end
        force dut.decode.wbEn = 1'b0;
        release dut.decode.wbEn;
        release dut.decode.wbReg;
        release dut.decode.wbData;
    endtask

    task automatic loadProgram(input int base, input int len);
        int i;
        for (i = 0; i < len; i++) begin
            @(posedge clk);
            ldWe <= 1'b1;
            ldAddr <= wiscPkg::wordT'(i);
            ldData <= image[base + i];
            refMem[i] = image[base + i];
        end
        @(posedge clk);
        ldWe <= 1'b0;
    endtask

    task automatic runTest(input int t, input string name);
        int errBefore;
        int expCount;
        errBefore = errors;
        @(posedge clk);
        run <= 1'b0;
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        clearRegs();
        loadProgram(startAt[t], lenOf[t]);
        expCount = referenceRun();
        compare("halted", halted, 1'b0);
        commits = 0;
        checking = 1'b1;
        @(posedge clk);
        run <= 1'b1;
        while (!halted) begin
            @(posedge clk);
        end
        // Anything still in flight behind HALT gets a chance to show up
        repeat (10) @(posedge clk);
        checking = 1'b0;
        compare("commitCount", commits, expCount);
        if (errors == errBefore) begin
            testsOk++;
            $display("Test %0d %s: ok, %0d commits", t + 1, name, commits);
        end else begin
            testsBad++;
            $display("Test %0d %s: %0d errors", t + 1, name, errors - errBefore);
        end
    endtask

    // Commit trace checked in order against the reference
    always @(negedge clk) begin
        if (checking && wbEn) begin
            if (expReg.size() == 0) begin
                $display("Unexpected commit to register %0d after the last expected write",
                         wbReg);
                errors++;
            end else begin
                compare("wbReg", wbReg, expReg.pop_front());
                compare("wbData", wbData, expData.pop_front());
            end
            commits++;
        end
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles", budget);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        run = 1'b0;
        ldWe = 1'b0;
        ldAddr = '0;
        ldData = '0;
        restart = 1'b0;
        checking = 1'b0;
        commits = 0;
        errors = 0;
        testsOk = 0;
        testsBad = 0;
        seed = 32'h395a8c55;
        buildPrograms();
        budget = fill * 20;
        runTest(0, "dependent ALU chain");
        runTest(1, "random ADDI and ALU");
        runTest(2, "store then load");
        runTest(3, "BEQZ and J flow");
        runTest(4, "HALT stops commits");
        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors total",
                 testsOk, testsBad, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sources.f
wiscPkg.sv
unifiedMem.sv
memArbiter.sv
fetchUnit.sv
hazardDetect.sv
decodeStage.sv
executeStage.sv
memStage.sv
wiscCore.sv
tbClock.sv
wiscCoreTb.sv

//--- Bender.yml
package:
  name: wisc_core

sources:
  - wiscPkg.sv
  - unifiedMem.sv
  - memArbiter.sv
  - fetchUnit.sv
  - hazardDetect.sv
  - decodeStage.sv
  - executeStage.sv
  - memStage.sv
  - wiscCore.sv
  - target: test
    files:
      - tbClock.sv
      - wiscCoreTb.sv
